// File: verilog/cpuPkg.sv
package cpuPkg;

    typedef logic [15:0] dataWord;
    typedef logic [2:0]  regIndex;

    // Codes 8 to 15 are left undefined and flagged in execute
    typedef logic [3:0]  aluOp;

    localparam aluOp aluAdd   = 4'd0;
    localparam aluOp aluSub   = 4'd1;
    localparam aluOp aluAnd   = 4'd2;
    localparam aluOp aluOr    = 4'd3;
    localparam aluOp aluXor   = 4'd4;
    localparam aluOp aluShl   = 4'd5;
    localparam aluOp aluSlt   = 4'd6;
    localparam aluOp aluPassB = 4'd7;

    // ****************************************
    // Pipeline bundles
    // ****************************************

    typedef struct packed {
        dataWord rsVal;
        dataWord rtVal;
        dataWord imm;
        dataWord pc;
        regIndex rs;
        regIndex rt;
        regIndex writeReg;
        logic    rsValid;
        logic    rtValid;
        logic    writeRegValid;
        aluOp    aluSel;
        logic    useImm;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    regWrite;
        logic    branch;
        logic    jump;
        logic    halt;
        logic    decodeErr;
    } idExBundle;

    typedef struct packed {
        dataWord aluRes;
        dataWord memWriteData;
        dataWord brAddr;
        dataWord jumpAddr;
        regIndex writeReg;
        regIndex rt;
        logic    rtValid;
        logic    writeRegValid;
        logic    branchTake;
        logic    jump;
        logic    memRead;
        logic    memWrite;
        logic    halt;
        logic    memToReg;
        logic    regWrite;
        logic    err;
    } exMemBundle;

    typedef struct packed {
        logic    regWrite;
        regIndex writeReg;
        dataWord writeData;
        logic    halt;
        logic    err;
    } wbBundle;

endpackage

// File: verilog/forwardUnit.sv
module forwardUnit (
    input  cpuPkg::idExBundle  idEx,
    input  cpuPkg::exMemBundle exMem,
    input  cpuPkg::wbBundle    wb,
    output cpuPkg::dataWord    opA,
    output cpuPkg::dataWord    opB
);

    logic exSrcOk;
    logic exFwdA;
    logic exFwdB;
    logic wbFwdA;
    logic wbFwdB;

    // A load result is not known until MEM, so EX/MEM loads never forward
    assign exSrcOk = exMem.regWrite && exMem.writeRegValid && !exMem.memToReg;

    assign exFwdA = exSrcOk && idEx.rsValid && (exMem.writeReg == idEx.rs);
    assign exFwdB = exSrcOk && idEx.rtValid && (exMem.writeReg == idEx.rt);

    assign wbFwdA = wb.regWrite && idEx.rsValid && (wb.writeReg == idEx.rs);
    assign wbFwdB = wb.regWrite && idEx.rtValid && (wb.writeReg == idEx.rt);

    // Youngest producer first
    always_comb begin
        if (exFwdA) begin
            opA = exMem.aluRes;
        end else if (wbFwdA) begin
            opA = wb.writeData;
        end else begin
            opA = idEx.rsVal;
        end
    end

    always_comb begin
        if (exFwdB) begin
            opB = exMem.aluRes;
        end else if (wbFwdB) begin
            opB = wb.writeData;
        end else begin
            opB = idEx.rtVal;
        end
    end

endmodule

// File: verilog/executeStage.sv
module executeStage (
    input  cpuPkg::idExBundle  idEx,
    input  cpuPkg::dataWord    opA,
    input  cpuPkg::dataWord    opB,
    output cpuPkg::exMemBundle ex,
    output logic               errExec,
    output logic               errTarget
);

    localparam cpuPkg::dataWord reservedVector = 16'hFFFF;

    cpuPkg::dataWord aluB;
    cpuPkg::dataWord aluRes;
    cpuPkg::dataWord brAddr;
    cpuPkg::dataWord jumpAddr;
    logic            branchTake;

    assign aluB = idEx.useImm ? idEx.imm : opB;

    // ****************************************
    // ALU
    // ****************************************

    always_comb begin
        errExec = 1'b0;
        case (idEx.aluSel)
            cpuPkg::aluAdd: aluRes = opA + aluB;
            cpuPkg::aluSub: aluRes = opA - aluB;
            cpuPkg::aluAnd: aluRes = opA & aluB;
            cpuPkg::aluOr: aluRes = opA | aluB;
            cpuPkg::aluXor: aluRes = opA ^ aluB;
            cpuPkg::aluShl: aluRes = opA << aluB[3:0];
            cpuPkg::aluSlt: aluRes = {15'b0, $signed(opA) < $signed(aluB)};
            cpuPkg::aluPassB: aluRes = aluB;
            default: begin
                aluRes = '0;
                errExec = 1'b1;
            end
        endcase
    end

    // ****************************************
    // Branch and jump resolution
    // ****************************************

    // Branch if zero
    assign branchTake = idEx.branch && (aluRes == '0);
    assign brAddr = idEx.pc + 16'd1 + idEx.imm;
    assign jumpAddr = opA + idEx.imm;

    always_comb begin
        errTarget = 1'b0;
        if (branchTake && brAddr == reservedVector) begin
            errTarget = 1'b1;
        end
        if (idEx.jump && jumpAddr == reservedVector) begin
            errTarget = 1'b1;
        end
    end

    always_comb begin
        ex.aluRes = aluRes;
        ex.memWriteData = opB;
        ex.brAddr = brAddr;
        ex.jumpAddr = jumpAddr;
        ex.writeReg = idEx.writeReg;
        ex.rt = idEx.rt;
        ex.rtValid = idEx.rtValid;
        ex.writeRegValid = idEx.writeRegValid;
        ex.branchTake = branchTake;
        ex.jump = idEx.jump;
        ex.memRead = idEx.memRead;
        ex.memWrite = idEx.memWrite;
        ex.halt = idEx.halt;
        ex.memToReg = idEx.memToReg;
        ex.regWrite = idEx.regWrite;
        // Decode error only; execute errors are merged in EX/MEM
        ex.err = idEx.decodeErr;
    end

    // Decoder emits at most one control transfer per slot
    always_comb begin
        assert (!(idEx.branch && idEx.jump))
            else $error("branch and jump both set in execute");
    end

endmodule

// File: verilog/exMemReg.sv
module exMemReg (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::exMemBundle ex,
    input  logic               errExec,
    input  logic               errTarget,
    input  logic               writeExMem,
    input  logic               controlZero,
    output cpuPkg::exMemBundle exMem
);

    cpuPkg::exMemBundle loadVal;
    cpuPkg::exMemBundle nextVal;

    // ****************************************
    // Load or hold
    // ****************************************

    always_comb begin
        loadVal = ex;
        loadVal.err = ex.err | errExec | errTarget;
    end

    always_comb begin
        if (writeExMem) begin
            nextVal = loadVal;
        end else begin
            nextVal = exMem;
        end

        // Wrong-path slot loses every side effect
        if (controlZero) begin
            nextVal.memWrite = 1'b0;
            nextVal.regWrite = 1'b0;
            nextVal.branchTake = 1'b0;
            nextVal.jump = 1'b0;
            nextVal.memRead = 1'b0;
            nextVal.halt = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem <= nextVal;
        end
    end

    // ****************************************
    // Checks
    // ****************************************

    // A slot is a load or a store, never both
    assert property (@(posedge clk) disable iff (reset)
        !(exMem.memRead && exMem.memWrite))
        else $error("EX/MEM holds both memRead and memWrite");

endmodule

// File: verilog/hazardControl.sv
module hazardControl (
    input  logic               clk,
    input  logic               reset,
    input  logic               hold,
    input  cpuPkg::exMemBundle exMem,
    output logic               writeExMem,
    output logic               controlZero,
    output logic               wbBubble
);

    logic haltSeen;
    logic redirectTaken;

    always_ff @(posedge clk) begin
        if (reset) begin
            haltSeen <= 1'b0;
        end else if (exMem.halt) begin
            haltSeen <= 1'b1;
        end
    end

    assign redirectTaken = exMem.branchTake || exMem.jump;

    assign writeExMem = !hold;
    assign wbBubble = hold;

    // Squash the slot behind a redirect, and everything behind a halt
    assign controlZero = !hold && (redirectTaken || exMem.halt || haltSeen);

    // A halt slot carries no control transfer
    assert property (@(posedge clk) disable iff (reset)
        exMem.halt |-> !redirectTaken)
        else $error("halt and redirect together in EX/MEM");

endmodule

// File: verilog/memoryStage.sv
module memoryStage #(
    parameter int memWords = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  cpuPkg::exMemBundle exMem,
    input  logic               wbBubble,
    output cpuPkg::wbBundle    wb
);

    localparam int addrBits = $clog2(memWords);

    cpuPkg::dataWord       mem [memWords];
    logic [addrBits-1:0]   memIdx;
    logic                  memAccess;
    logic                  rangeErr;
    cpuPkg::dataWord       readData;
    cpuPkg::wbBundle       wbNext;

    assign memIdx = exMem.aluRes[addrBits-1:0];
    assign memAccess = exMem.memRead || exMem.memWrite;
    assign rangeErr = memAccess && (32'(exMem.aluRes) >= memWords);

    // ****************************************
    // Data memory
    // ****************************************

    always_comb begin
        if (exMem.memRead && !rangeErr) begin
            readData = mem[memIdx];
        end else begin
            readData = '0;
        end
    end

    // No store while EX/MEM is frozen, or it would repeat
    always_ff @(posedge clk) begin
        if (exMem.memWrite && !wbBubble && !rangeErr) begin
            mem[memIdx] <= exMem.memWriteData;
        end
    end

    // ****************************************
    // MEM/WB register
    // ****************************************

    always_comb begin
        wbNext.regWrite = exMem.regWrite && !wbBubble;
        wbNext.writeReg = exMem.writeReg;
        if (exMem.memToReg) begin
            wbNext.writeData = readData;
        end else begin
            wbNext.writeData = exMem.aluRes;
        end
        wbNext.halt = exMem.halt && !wbBubble;
        // Bubble carries no instruction
        wbNext.err = (exMem.err || rangeErr) && !wbBubble;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= wbNext;
        end
    end

endmodule

// File: verilog/backEndTop.sv
module backEndTop #(
    parameter int memWords = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  cpuPkg::idExBundle idEx,
    input  logic              hold,
    output logic              redirectValid,
    output cpuPkg::dataWord   redirectAddr,
    output cpuPkg::wbBundle   wb
);

    cpuPkg::dataWord    opA;
    cpuPkg::dataWord    opB;
    cpuPkg::exMemBundle ex;
    cpuPkg::exMemBundle exMem;
    logic               errExec;
    logic               errTarget;
    logic               writeExMem;
    logic               controlZero;
    logic               wbBubble;

    forwardUnit fwd (
        .idEx  (idEx),
        .exMem (exMem),
        .wb    (wb),
        .opA   (opA),
        .opB   (opB)
    );

    executeStage exec (
        .idEx      (idEx),
        .opA       (opA),
        .opB       (opB),
        .ex        (ex),
        .errExec   (errExec),
        .errTarget (errTarget)
    );

    exMemReg exMemPipe (
        .clk         (clk),
        .reset       (reset),
        .ex          (ex),
        .errExec     (errExec),
        .errTarget   (errTarget),
        .writeExMem  (writeExMem),
        .controlZero (controlZero),
        .exMem       (exMem)
    );

    hazardControl hazard (
        .clk         (clk),
        .reset       (reset),
        .hold        (hold),
        .exMem       (exMem),
        .writeExMem  (writeExMem),
        .controlZero (controlZero),
        .wbBubble    (wbBubble)
    );

    memoryStage #(
        .memWords (memWords)
    ) memStage (
        .clk      (clk),
        .reset    (reset),
        .exMem    (exMem),
        .wbBubble (wbBubble),
        .wb       (wb)
    );

    // Redirect straight from EX/MEM
    assign redirectValid = exMem.branchTake || exMem.jump;
    assign redirectAddr = exMem.jump ? exMem.jumpAddr : exMem.brAddr;

endmodule

// File: dv/backEndTb.sv
module backEndTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int memWords = 256;
    // Slot index where the halt goes
    localparam int instrCount = 240;
    localparam int cycleLimit = 4 * instrCount + 200;

    logic                clk;
    logic                reset;
    cpuPkg::idExBundle   idEx;
    logic                hold;
    logic                redirectValid;
    cpuPkg::dataWord     redirectAddr;
    cpuPkg::wbBundle     wb;

    backEndTop #(
        .memWords (memWords)
    ) uut (
        .clk           (clk),
        .reset         (reset),
        .idEx          (idEx),
        .hold          (hold),
        .redirectValid (redirectValid),
        .redirectAddr  (redirectAddr),
        .wb            (wb)
    );

    logic [31:0]       rngState;
    cpuPkg::dataWord   archRf [8];
    cpuPkg::dataWord   committedRf [8];
    cpuPkg::dataWord   modelMem [memWords];
    int                storeIdx [memWords];
    cpuPkg::wbBundle   wbQ [$];
    string             nameQ [$];
    cpuPkg::idExBundle pend;
    cpuPkg::wbBundle   pendExp;
    string             pendName;
    logic              pendRedir;
    cpuPkg::dataWord   pendAddr;
    logic              squashNext;
    logic              prevLoad;
    cpuPkg::regIndex   prevLoadReg;
    cpuPkg::regIndex   prevWriteReg;
    int                idx;
    int                afterHalt;
    int                lastStore;
    cpuPkg::dataWord   lastStoreAddr;
    logic              holdCur;
    string             testName;
    int                cycleCount = 0;

    // Expected state of the DUT outputs for the coming cycle
    logic              wbCommit;
    cpuPkg::wbBundle   expWb;
    string             checkName;
    logic              expRedirValid;
    cpuPkg::dataWord   expRedirAddr;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ****************************************
    // Helpers
    // ****************************************

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic cpuPkg::dataWord aluModel(input cpuPkg::aluOp op,
                                                 input cpuPkg::dataWord a,
                                                 input cpuPkg::dataWord b);
        case (op)
            cpuPkg::aluAdd: return a + b;
            cpuPkg::aluSub: return a - b;
            cpuPkg::aluAnd: return a & b;
            cpuPkg::aluOr: return a | b;
            cpuPkg::aluXor: return a ^ b;
            cpuPkg::aluShl: return a << b[3:0];
            cpuPkg::aluSlt: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            cpuPkg::aluPassB: return b;
            default: return 16'd0;
        endcase
    endfunction

    // Destinations avoid r0
    function automatic cpuPkg::regIndex pickDest(input logic [2:0] v);
        return (v == 3'd0) ? 3'd1 : v;
    endfunction

    task automatic stopFailed();
        $display("Test FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic reportValue(input string name, input logic [31:0] expV,
                               input logic [31:0] actV);
        $display("ERROR %s: expected %h, actual %h", name, expV, actV);
        stopFailed();
    endtask

    task automatic randomAlu(inout cpuPkg::idExBundle d, input logic [31:0] r);
        d.aluSel = cpuPkg::aluOp'({1'b0, r[18:16]});
        d.useImm = r[19];
        d.imm = r[31:16];
        // Lean on the last producer to exercise EX/MEM forwarding
        d.rs = r[20] ? prevWriteReg : r[23:21];
        d.rt = r[26:24];
        d.writeReg = pickDest(r[29:27]);
        d.rsValid = 1'b1;
        d.rtValid = 1'b1;
        d.writeRegValid = 1'b1;
        d.regWrite = 1'b1;
    endtask

    task automatic setupMem(inout cpuPkg::idExBundle d, input cpuPkg::dataWord addr,
                            input logic isStore, input logic [31:0] r);
        d.aluSel = cpuPkg::aluAdd;
        d.useImm = 1'b1;
        d.imm = addr;
        d.rs = 3'd0;
        d.rsValid = 1'b1;
        d.rt = r[26:24];
        d.rtValid = 1'b1;
        if (isStore) begin
            d.memWrite = 1'b1;
        end else begin
            d.memRead = 1'b1;
            d.memToReg = 1'b1;
            d.regWrite = 1'b1;
            d.writeRegValid = 1'b1;
            d.writeReg = pickDest(r[29:27]);
        end
    endtask

    // ****************************************
    // Instruction generator and reference model
    // ****************************************

    task automatic genInstr();
        cpuPkg::idExBundle d;
        cpuPkg::wbBundle   e;
        cpuPkg::dataWord   a;
        cpuPkg::dataWord   b;
        cpuPkg::dataWord   res;
        cpuPkg::dataWord   tgt;
        cpuPkg::dataWord   rdData;
        logic [31:0]       r;
        logic              rangeErr;
        logic              taken;
        int                addr;
        d = '0;
        e = '0;
        r = nextRand();
        pendRedir = 1'b0;
        pendAddr = '0;
        if (squashNext) begin
            squashNext = 1'b0;
        end else if (idx < 7) begin
            testName = "seed";
            d.aluSel = cpuPkg::aluPassB;
            d.useImm = 1'b1;
            d.imm = r[15:0];
            d.writeReg = cpuPkg::regIndex'(idx + 1);
            d.writeRegValid = 1'b1;
            d.regWrite = 1'b1;
        end else if (idx < 120) begin
            testName = "alu";
            randomAlu(d, r);
        end else if (idx < 170) begin
            testName = "memory";
            addr = int'(r[23:16]);
            if (r[1:0] == 2'd3) begin
                setupMem(d, 16'h0100 + {8'h00, r[15:8]}, r[2], r);
            end else if (r[1:0] == 2'd0) begin
                setupMem(d, cpuPkg::dataWord'(addr), 1'b1, r);
            end else if (storeIdx[addr] >= 0 && storeIdx[addr] + 2 <= idx) begin
                setupMem(d, cpuPkg::dataWord'(addr), 1'b0, r);
            end else if (lastStore >= 0 && lastStore + 2 <= idx) begin
                setupMem(d, lastStoreAddr, 1'b0, r);
            end else begin
                setupMem(d, cpuPkg::dataWord'(addr), 1'b1, r);
            end
        end else if (idx < 210) begin
            testName = "branch";
            if (r[1:0] == 2'd3) begin
                randomAlu(d, r);
            end else if (r[1:0] == 2'd2) begin
                d.jump = 1'b1;
                d.rs = r[23:21];
                d.rsValid = 1'b1;
                d.imm = r[15:0];
            end else begin
                d.branch = 1'b1;
                d.aluSel = cpuPkg::aluSub;
                d.rs = r[23:21];
                // Equal registers always give a taken branch
                d.rt = r[0] ? r[26:24] : r[23:21];
                d.rsValid = 1'b1;
                d.rtValid = 1'b1;
                d.imm = {8'h00, r[15:8]};
            end
        end else if (idx < instrCount) begin
            testName = "error";
            if (r[1:0] == 2'd2) begin
                d.jump = 1'b1;
                d.rsValid = 1'b1;
                d.imm = 16'hFFFF;
            end else begin
                randomAlu(d, r);
                if (r[1:0] == 2'd0) begin
                    d.decodeErr = 1'b1;
                end else if (r[1:0] == 2'd1) begin
                    d.aluSel = cpuPkg::aluOp'({1'b1, r[6:4]});
                end
            end
        end else if (afterHalt < 0) begin
            testName = "halt";
            d.halt = 1'b1;
            afterHalt = 0;
        end else begin
            testName = "after halt";
            // A jump behind the halt, which EX/MEM must squash
            d.jump = 1'b1;
            d.imm = {1'b0, r[14:0]};
            afterHalt++;
        end

        // No reads of a load result in the very next slot
        if (prevLoad && d.rsValid && d.rs == prevLoadReg) begin
            d.rs = 3'd0;
        end
        if (prevLoad && d.rtValid && d.rt == prevLoadReg) begin
            d.rt = 3'd0;
        end
        d.pc = cpuPkg::dataWord'(idx);

        a = archRf[d.rs];
        b = d.useImm ? d.imm : archRf[d.rt];
        res = aluModel(d.aluSel, a, b);
        rangeErr = (d.memRead || d.memWrite) && (int'(res) >= memWords);
        rdData = '0;
        if (d.memRead && !rangeErr) begin
            rdData = modelMem[int'(res)];
        end
        if (d.memWrite && !rangeErr) begin
            modelMem[int'(res)] = archRf[d.rt];
            storeIdx[int'(res)] = idx;
            lastStore = idx;
            lastStoreAddr = res;
        end
        taken = d.branch && (res == 16'd0);
        tgt = d.jump ? a + d.imm : d.pc + 16'd1 + d.imm;
        if (taken || d.jump) begin
            pendRedir = 1'b1;
            pendAddr = tgt;
            squashNext = 1'b1;
        end

        e.regWrite = d.regWrite;
        e.writeReg = d.writeReg;
        e.writeData = d.memToReg ? rdData : res;
        e.halt = d.halt;
        e.err = d.decodeErr || (d.aluSel > cpuPkg::aluPassB) || rangeErr
            || ((taken || d.jump) && tgt == 16'hFFFF);
        if (d.regWrite) begin
            archRf[d.writeReg] = e.writeData;
            prevWriteReg = d.writeReg;
        end
        prevLoad = d.memRead;
        prevLoadReg = d.writeReg;

        // Nothing behind a halt reaches writeback or redirects
        if (afterHalt > 0) begin
            e = '0;
            pendRedir = 1'b0;
            squashNext = 1'b0;
        end

        pend = d;
        pendExp = e;
        pendName = testName;
        idx++;
    endtask

    task automatic stepCycle();
        cpuPkg::idExBundle d;
        logic [31:0]       r;
        if (wbCommit && expWb.regWrite) begin
            committedRf[expWb.writeReg] = expWb.writeData;
        end
        if (!holdCur) begin
            wbQ.push_back(pendExp);
            nameQ.push_back(pendName);
            expWb <= wbQ.pop_front();
            checkName <= nameQ.pop_front();
            wbCommit <= 1'b1;
            expRedirValid <= pendRedir;
            expRedirAddr <= pendAddr;
            genInstr();
        end else begin
            wbCommit <= 1'b0;
        end
        r = nextRand();
        holdCur = (r[3:0] < 4'd3);
        hold <= holdCur;
        d = pend;
        d.rsVal = committedRf[pend.rs];
        d.rtVal = committedRf[pend.rt];
        idEx <= d;
    endtask

    // ****************************************
    // Checks
    // ****************************************

    assert property (@(posedge clk) disable iff (reset) wbCommit |-> wb == expWb)
        else reportValue(checkName, 32'($sampled(expWb)), 32'($sampled(wb)));

    assert property (@(posedge clk) disable iff (reset)
        !wbCommit |-> !wb.regWrite && !wb.halt && !wb.err)
        else begin
            $display("A held cycle produced a committed instruction at writeback");
            stopFailed();
        end

    assert property (@(posedge clk) disable iff (reset) redirectValid == expRedirValid)
        else reportValue("redirect valid", 32'($sampled(expRedirValid)),
                         32'($sampled(redirectValid)));

    assert property (@(posedge clk) disable iff (reset)
        expRedirValid |-> redirectAddr == expRedirAddr)
        else reportValue("redirect target", 32'($sampled(expRedirAddr)),
                         32'($sampled(redirectAddr)));

    assert property (@(posedge clk) disable iff (reset) wb.regWrite |-> wb.writeReg != 3'd0)
        else begin
            $display("Register zero was written at writeback");
            stopFailed();
        end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            stopFailed();
        end
    end

    // ****************************************
    // Main sequence
    // ****************************************

    initial begin
        reset = 1'b1;
        hold = 1'b0;
        idEx = '0;
        rngState = 32'h64ccf825;
        for (int i = 0; i < 8; i++) begin
            archRf[i] = '0;
            committedRf[i] = '0;
        end
        for (int i = 0; i < memWords; i++) begin
            storeIdx[i] = -1;
        end
        // EX/MEM starts out as an empty slot
        wbQ.push_back('0);
        nameQ.push_back("reset");
        pend = '0;
        pendExp = '0;
        pendName = "reset";
        pendRedir = 1'b0;
        pendAddr = '0;
        squashNext = 1'b0;
        prevLoad = 1'b0;
        prevLoadReg = '0;
        prevWriteReg = 3'd1;
        idx = 0;
        afterHalt = -1;
        lastStore = -1;
        lastStoreAddr = '0;
        holdCur = 1'b0;
        testName = "reset";
        wbCommit = 1'b0;
        expWb = '0;
        checkName = "reset";
        expRedirValid = 1'b0;
        expRedirAddr = '0;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (afterHalt < 6) begin
            @(posedge clk);
            stepCycle();
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: src.f
verilog/cpuPkg.sv
verilog/forwardUnit.sv
verilog/executeStage.sv
verilog/exMemReg.sv
verilog/hazardControl.sv
verilog/memoryStage.sv
verilog/backEndTop.sv
dv/backEndTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= backEndTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/simv: $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o simv

sim: $(BUILD_DIR)/simv
	-./$(BUILD_DIR)/simv | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
